// ==== src/uart_pkg.sv ====
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame format, 8 data bits with even parity.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_BITS  = 8;
    localparam int OVERSAMPLE = 16;            // Ticks per bit.
    localparam int MID_TICK   = OVERSAMPLE / 2; // Start bit check point.

    typedef logic [DATA_BITS-1:0] byte_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receiver FSM states.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        START  = 3'd1,
        DATA   = 3'd2,
        PARITY = 3'd3,
        STOP   = 3'd4
    } rx_state_t;

endpackage

// ==== src/baud_tick_gen.sv ====
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic clk,
    input  logic nRst,
    output logic tick
);

    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == LAST);

    // Free-running divider, one tick per wrap.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            tick <= wrap; // Registered, so first tick lands CLKS_PER_TICK clocks out.
        end
    end

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic            clk,
    input  logic            nRst,
    input  logic            tick,
    input  logic            rx_serial,
    input  logic            take,
    output logic            valid,
    output uart_pkg::byte_t data,
    output logic            parity_err,
    output logic            frame_err
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int IDX_W  = $clog2(DATA_BITS);

    logic              rx_meta;
    logic              rx_sync;
    rx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [IDX_W-1:0]  bit_idx;
    logic              line_idle;
    logic              stop_done;
    byte_t             shift;
    logic              parity_bit;
    logic              mid_start;
    logic              bit_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizer, idles high.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
        end
    end

    assign mid_start = tick && (tick_cnt == TICK_W'(MID_TICK - 1));
    assign bit_end   = tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= IDLE;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            line_idle <= 1'b0;
            stop_done <= 1'b0;
        end else begin
            stop_done <= 1'b0;
            case (state)
                IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_sync) begin
                        line_idle <= 1'b1;
                    end else if (tick && line_idle) begin
                        state <= START;
                    end
                end
                START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;
                        state    <= rx_sync ? IDLE : DATA; // High here is a glitch.
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(DATA_BITS - 1)) begin
                            state <= PARITY;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                PARITY: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        state    <= STOP;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        tick_cnt  <= '0;
                        stop_done <= 1'b1;
                        line_idle <= rx_sync; // A low stop waits for the line to recover.
                        state     <= IDLE;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Shift register and result, loaded on the sample ticks.
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            shift <= {rx_sync, shift[DATA_BITS-1:1]}; // LSB first.
        end
        if (state == PARITY && bit_end) begin
            parity_bit <= rx_sync;
        end
        if (state == STOP && bit_end) begin
            data       <= shift;
            parity_err <= ^{shift, parity_bit};
            frame_err  <= !rx_sync;
        end
    end

    // Held until the collector takes it.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            valid <= 1'b0;
        end else if (stop_done) begin
            valid <= 1'b1;
        end else if (take) begin
            valid <= 1'b0;
        end
    end

    take_needs_valid: assert property (@(posedge clk) disable iff (!nRst) take |-> valid);

    valid_held: assert property (@(posedge clk) disable iff (!nRst)
        valid && !take |=> valid && $stable({data, parity_err, frame_err}));

endmodule

// ==== src/rx_collector.sv ====
`timescale 1ns/1ps

module rx_collector #(
    parameter int NUM_CH = 4
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  logic            [NUM_CH-1:0]         valid,
    input  uart_pkg::byte_t [NUM_CH-1:0]         data,
    input  logic            [NUM_CH-1:0]         parity_err,
    input  logic            [NUM_CH-1:0]         frame_err,
    output logic            [NUM_CH-1:0]         take,
    output logic                                 out_valid,
    output logic            [$clog2(NUM_CH)-1:0] out_ch,
    output uart_pkg::byte_t                      out_data,
    output logic                                 out_parity_err,
    output logic                                 out_frame_err
);

    localparam int CH_W = $clog2(NUM_CH);

    logic [CH_W-1:0]   ptr;
    logic [NUM_CH-1:0] eligible;
    logic              pick_any;
    logic [CH_W-1:0]   pick_ch;

    // A channel taken last cycle still shows valid for one more clock.
    assign eligible = valid & ~take;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick, first eligible at or after ptr.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int idx;
        pick_any = 1'b0;
        pick_ch  = ptr;
        idx      = 0;
        for (int k = 0; k < NUM_CH; k++) begin
            idx = (int'(ptr) + k) % NUM_CH;
            if (!pick_any && eligible[idx]) begin
                pick_any = 1'b1;
                pick_ch  = CH_W'(idx);
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ptr       <= '0;
            take      <= '0;
            out_valid <= 1'b0;
        end else begin
            take      <= '0;
            out_valid <= pick_any; // One clock per served byte.
            if (pick_any) begin
                take[pick_ch] <= 1'b1;
                if (pick_ch == CH_W'(NUM_CH - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= pick_ch + 1'b1;
                end
            end
        end
    end

    // Output payload, captured with the take.
    always_ff @(posedge clk) begin
        if (pick_any) begin
            out_ch         <= pick_ch;
            out_data       <= data[pick_ch];
            out_parity_err <= parity_err[pick_ch];
            out_frame_err  <= frame_err[pick_ch];
        end
    end

    // The taken channel drops valid on the next clock.
    take_clears_valid: assert property (@(posedge clk) disable iff (!nRst)
        |take |=> (valid & $past(take)) == '0);

endmodule

// ==== src/uart_rx_array.sv ====
`timescale 1ns/1ps

module uart_rx_array #(
    parameter int NUM_CH        = 4,
    parameter int CLKS_PER_TICK = 4
) (
    input  logic                      clk,
    input  logic                      nRst,
    input  logic [NUM_CH-1:0]         rx_serial,
    output logic                      out_valid,
    output logic [$clog2(NUM_CH)-1:0] out_ch,
    output uart_pkg::byte_t           out_data,
    output logic                      out_parity_err,
    output logic                      out_frame_err
);

    import uart_pkg::*;

    logic               tick;
    logic  [NUM_CH-1:0] ch_valid;
    byte_t [NUM_CH-1:0] ch_data;
    logic  [NUM_CH-1:0] ch_parity_err;
    logic  [NUM_CH-1:0] ch_frame_err;
    logic  [NUM_CH-1:0] ch_take;

    // Shared 16x oversampling tick.
    baud_tick_gen #(
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) u_tick (
        .clk  (clk),
        .nRst (nRst),
        .tick (tick)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        uart_rx u_rx (
            .clk        (clk),
            .nRst       (nRst),
            .tick       (tick),
            .rx_serial  (rx_serial[i]),
            .take       (ch_take[i]),
            .valid      (ch_valid[i]),
            .data       (ch_data[i]),
            .parity_err (ch_parity_err[i]),
            .frame_err  (ch_frame_err[i])
        );
    end

    rx_collector #(
        .NUM_CH (NUM_CH)
    ) u_collector (
        .clk            (clk),
        .nRst           (nRst),
        .valid          (ch_valid),
        .data           (ch_data),
        .parity_err     (ch_parity_err),
        .frame_err      (ch_frame_err),
        .take           (ch_take),
        .out_valid      (out_valid),
        .out_ch         (out_ch),
        .out_data       (out_data),
        .out_parity_err (out_parity_err),
        .out_frame_err  (out_frame_err)
    );

endmodule

// ==== verification/uart_rx_array_tb.sv ====
`timescale 1ns/1ps

module uart_rx_array_tb;

    import uart_pkg::*;

    localparam int NUM_CH        = 4;
    localparam int CLKS_PER_TICK = 4;
    localparam int BIT_CLKS      = CLKS_PER_TICK * OVERSAMPLE; // Clocks per bit.
    localparam int TIMEOUT_CLKS  = 20 * BIT_CLKS;
    localparam int CH_W          = $clog2(NUM_CH);

    typedef logic [CH_W-1:0] ch_t;

    logic              clk;
    logic              nRst;
    logic [NUM_CH-1:0] rx_serial;
    logic              out_valid;
    ch_t               out_ch;
    byte_t             out_data;
    logic              out_parity_err;
    logic              out_frame_err;

    // Records of every delivered byte.
    time   mon_t[$];
    ch_t   mon_ch[$];
    byte_t mon_data[$];
    logic  mon_perr[$];
    logic  mon_ferr[$];

    int          errors;
    int          tests_passed;
    int          tests_failed;

    uart_rx_array #(
        .NUM_CH        (NUM_CH),
        .CLKS_PER_TICK (CLKS_PER_TICK)
    ) uut (
        .clk            (clk),
        .nRst           (nRst),
        .rx_serial      (rx_serial),
        .out_valid      (out_valid),
        .out_ch         (out_ch),
        .out_data       (out_data),
        .out_parity_err (out_parity_err),
        .out_frame_err  (out_frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (nRst && out_valid) begin
            mon_t.push_back($time);
            mon_ch.push_back(out_ch);
            mon_data.push_back(out_data);
            mon_perr.push_back(out_parity_err);
            mon_ferr.push_back(out_frame_err);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line driver and checking helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_frame(input ch_t ch, input byte_t b, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        bits = {!bad_stop, (^b) ^ bad_parity, b, 1'b0}; // Start bit goes out first.
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            rx_serial[ch] = bits[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx_serial[ch] = 1'b1;
    endtask

    task automatic clear_records();
        mon_t.delete();
        mon_ch.delete();
        mon_data.delete();
        mon_perr.delete();
        mon_ferr.delete();
    endtask

    task automatic wait_for_count(input int n);
        int cnt;
        cnt = 0;
        while (mon_data.size() < n && cnt < TIMEOUT_CLKS) begin
            @(posedge clk);
            cnt++;
        end
        if (mon_data.size() < n) begin
            $display("Timeout at %0t: waited for %0d output bytes but saw only %0d",
                     $time, n, mon_data.size());
            errors++;
        end
        repeat (2 * BIT_CLKS) @(posedge clk); // Room for any stray extra byte.
        if (mon_data.size() > n) begin
            $display("Expected %0d output bytes but saw %0d", n, mon_data.size());
            errors++;
        end
    endtask

    task automatic check_record(input int idx, input ch_t ch, input byte_t b,
                                input logic perr, input logic ferr);
        if (idx >= mon_data.size()) begin
            $display("Output byte %0d never arrived", idx);
            errors++;
        end else begin
            if (mon_ch[idx] !== ch) begin
                $display("MISMATCH at %0t: out_ch expected %0d got %0d",
                         mon_t[idx], ch, mon_ch[idx]);
                errors++;
            end
            if (mon_data[idx] !== b) begin
                $display("MISMATCH at %0t: out_data expected %h got %h",
                         mon_t[idx], b, mon_data[idx]);
                errors++;
            end
            if (mon_perr[idx] !== perr) begin
                $display("MISMATCH at %0t: out_parity_err expected %b got %b",
                         mon_t[idx], perr, mon_perr[idx]);
                errors++;
            end
            if (mon_ferr[idx] !== ferr) begin
                $display("MISMATCH at %0t: out_frame_err expected %b got %b",
                         mon_t[idx], ferr, mon_ferr[idx]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    function automatic byte_t random_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_single();
        int e;
        e = errors;
        clear_records();
        send_frame(2'd0, 8'hA5, 1'b0, 1'b0);
        wait_for_count(1);
        check_record(0, 2'd0, 8'hA5, 1'b0, 1'b0);
        report_test("single byte", e);
    endtask

    task automatic test_parity();
        int e;
        e = errors;
        clear_records();
        send_frame(2'd2, 8'h3C, 1'b1, 1'b0); // Parity bit inverted.
        wait_for_count(1);
        check_record(0, 2'd2, 8'h3C, 1'b1, 1'b0);
        report_test("parity error", e);
    endtask

    task automatic test_framing();
        int e;
        e = errors;
        clear_records();
        send_frame(2'd3, 8'h81, 1'b0, 1'b1);
        wait_for_count(1);
        check_record(0, 2'd3, 8'h81, 1'b0, 1'b1);
        report_test("framing error", e);
    endtask

    task automatic test_glitch();
        int e;
        int cnt;
        e = errors;
        cnt = 0;
        clear_records();
        @(negedge clk);
        rx_serial[1] = 1'b0;
        repeat (BIT_CLKS / 4) @(negedge clk); // Well under half a bit.
        rx_serial[1] = 1'b1;
        while (mon_data.size() == 0 && cnt < TIMEOUT_CLKS) begin
            @(posedge clk);
            cnt++;
        end
        if (mon_data.size() != 0) begin
            $display("A short low pulse on channel 1 produced an output byte at %0t", mon_t[0]);
            errors++;
        end
        report_test("start glitch", e);
    endtask

    task automatic test_all_channels();
        int    e;
        int    hits;
        logic  dup;
        byte_t b[NUM_CH];
        e = errors;
        clear_records();
        for (int c = 0; c < NUM_CH; c++) begin
            do begin
                b[c] = random_byte();
                dup  = 1'b0;
                for (int k = 0; k < c; k++) begin
                    if (b[k] == b[c]) dup = 1'b1;
                end
            end while (dup);
        end
        fork
            send_frame(2'd0, b[0], 1'b0, 1'b0);
            send_frame(2'd1, b[1], 1'b0, 1'b0);
            send_frame(2'd2, b[2], 1'b0, 1'b0);
            send_frame(2'd3, b[3], 1'b0, 1'b0);
        join
        wait_for_count(NUM_CH);
        for (int c = 0; c < NUM_CH; c++) begin
            hits = 0;
            for (int i = 0; i < mon_data.size(); i++) begin
                if (mon_ch[i] == ch_t'(c)) begin
                    hits++;
                    check_record(i, ch_t'(c), b[c], 1'b0, 1'b0);
                end
            end
            if (hits != 1) begin
                $display("Channel %0d delivered %0d bytes instead of one", c, hits);
                errors++;
            end
        end
        report_test("all channels at once", e);
    endtask

    task automatic test_burst();
        int    e;
        byte_t b[8];
        e = errors;
        clear_records();
        for (int i = 0; i < 8; i++) begin
            b[i] = random_byte();
        end
        for (int i = 0; i < 8; i++) begin
            send_frame(2'd1, b[i], 1'b0, 1'b0);
        end
        wait_for_count(8);
        for (int i = 0; i < 8; i++) begin
            check_record(i, 2'd1, b[i], 1'b0, 1'b0);
        end
        report_test("back to back burst", e);
    endtask

    initial begin
        void'($urandom(32'h0294a1eb));
        rx_serial    = '1; // Lines idle high.
        nRst         = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        nRst = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);

        test_single();
        test_parity();
        test_framing();
        test_glitch();
        test_all_channels();
        test_burst();

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/rx_collector.sv
src/uart_rx_array.sv
verification/uart_rx_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART receive array testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module uart_rx_array_tb -f files.f \
    --Mdir obj_dir -o uart_rx_array_sim

./obj_dir/uart_rx_array_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
